/* verilog/fetch_pkg.sv */
package fetch_pkg;

    localparam int xlen = 32;

    // Instruction ROM geometry
    localparam int imem_words = 256;
    localparam int imem_idx_w = 8;

    // Predictor geometry
    localparam int bht_entries = 64;
    localparam int bht_idx_w   = 6;
    localparam int btb_entries = 16;
    localparam int btb_idx_w   = 4;
    localparam int btb_tag_w   = xlen - btb_idx_w - 2;

    localparam logic [xlen-1:0] reset_pc = '0;

    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;

    localparam logic [1:0] ctr_weak_nt = 2'b01;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // Same fetched word, seen as a branch or as a jal
    typedef union packed {
        b_fmt_t b_fmt;
        j_fmt_t j_fmt;
    } inst_word_u;

endpackage

/* verilog/branch_history_table.sv */
`timescale 1ns/10ps

module branch_history_table (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic [fetch_pkg::xlen-1:0] pc,

    input  logic                      resolve_valid,
    input  logic [fetch_pkg::xlen-1:0] resolve_pc,
    input  logic                      resolve_taken,

    output logic                      bht_taken
);
    import fetch_pkg::*;

    logic [1:0]           ctr [bht_entries];
    logic [bht_idx_w-1:0] rd_idx;
    logic [bht_idx_w-1:0] wr_idx;
    logic [1:0]           ctr_cur;
    logic [1:0]           ctr_next;

    assign rd_idx = pc[bht_idx_w+1:2];
    assign wr_idx = resolve_pc[bht_idx_w+1:2];

    // Upper counter bit is the direction
    assign bht_taken = ctr[rd_idx][1];

    assign ctr_cur = ctr[wr_idx];

    // Saturating 2-bit update
    always_comb begin
        ctr_next = ctr_cur;
        if (resolve_taken) begin
            if (ctr_cur != 2'b11) begin
                ctr_next = ctr_cur + 2'd1;
            end
        end else begin
            if (ctr_cur != 2'b00) begin
                ctr_next = ctr_cur - 2'd1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < bht_entries; i++) begin
                ctr[i] <= ctr_weak_nt;
            end
        end else if (resolve_valid) begin
            ctr[wr_idx] <= ctr_next;
        end
    end

    // Execute only reports word-aligned branch PCs
    resolve_pc_aligned_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        resolve_valid |-> (resolve_pc[1:0] == 2'b00)
    ) else $error("bht: misaligned resolve_pc %h", resolve_pc);

endmodule

/* verilog/branch_target_buffer.sv */
`timescale 1ns/10ps

module branch_target_buffer (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic [fetch_pkg::xlen-1:0] pc,

    input  logic                      resolve_valid,
    input  logic [fetch_pkg::xlen-1:0] resolve_pc,
    input  logic                      resolve_taken,
    input  logic [fetch_pkg::xlen-1:0] resolve_target,

    output logic                      btb_hit,
    output logic [fetch_pkg::xlen-1:0] btb_target
);
    import fetch_pkg::*;

    logic                 valid  [btb_entries];
    logic [btb_tag_w-1:0] tag    [btb_entries];
    logic [xlen-1:0]      target [btb_entries];

    logic [btb_idx_w-1:0] rd_idx;
    logic [btb_tag_w-1:0] rd_tag;
    logic [btb_idx_w-1:0] wr_idx;
    logic [btb_tag_w-1:0] wr_tag;
    logic                 fill;

    assign rd_idx = pc[btb_idx_w+1:2];
    assign rd_tag = pc[xlen-1:btb_idx_w+2];
    assign wr_idx = resolve_pc[btb_idx_w+1:2];
    assign wr_tag = resolve_pc[xlen-1:btb_idx_w+2];

    // Lookup
    assign btb_hit    = valid[rd_idx] && (tag[rd_idx] == rd_tag);
    assign btb_target = target[rd_idx];

    // Only taken branches allocate
    assign fill = resolve_valid && resolve_taken;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < btb_entries; i++) begin
                valid[i] <= 1'b0;
            end
        end else if (fill) begin
            valid[wr_idx] <= 1'b1;
        end
    end

    // Tag and target storage
    always_ff @(posedge clk) begin
        if (fill) begin
            tag[wr_idx]    <= wr_tag;
            target[wr_idx] <= resolve_target;
        end
    end

    // Invalid entries must mask the uninitialised tag store
    btb_hit_known_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        !$isunknown(btb_hit)
    ) else $error("btb: hit is unknown at pc %h", pc);

endmodule

/* verilog/fetch_steer.sv */
`timescale 1ns/10ps

module fetch_steer (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      pc_write,

    input  logic                      redirect_valid,
    input  logic [fetch_pkg::xlen-1:0] redirect_pc,

    input  fetch_pkg::inst_word_u     inst,
    input  logic                      bht_taken,
    input  logic                      btb_hit,
    input  logic [fetch_pkg::xlen-1:0] btb_target,

    output logic [fetch_pkg::xlen-1:0] pc,
    output logic                      pred_taken
);
    import fetch_pkg::*;

    logic            is_branch;
    logic            is_jal;
    logic            br_taken;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] jal_imm;
    logic [xlen-1:0] jal_target;
    logic [xlen-1:0] next_pc;

    // Opcode sits in the same bits for both views
    assign is_branch = (inst.b_fmt.opcode == opc_branch);
    assign is_jal    = (inst.b_fmt.opcode == opc_jal);

    // J-immediate rebuilt from its scattered fields
    assign jal_imm = {{11{inst.j_fmt.imm20}},
                      inst.j_fmt.imm20,
                      inst.j_fmt.imm19_12,
                      inst.j_fmt.imm11,
                      inst.j_fmt.imm10_1,
                      1'b0};

    assign pc_plus4   = pc + 32'd4;
    assign jal_target = pc + jal_imm;
    assign br_taken   = is_branch && btb_hit && bht_taken;

    always_comb begin
        if (is_jal) begin
            next_pc = jal_target;
        end else if (br_taken) begin
            next_pc = btb_target;
        end else begin
            next_pc = pc_plus4;
        end
    end

    assign pred_taken = is_jal || br_taken;

    // Redirect wins over a stall
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= reset_pc;
        end else if (redirect_valid) begin
            pc <= redirect_pc;
        end else if (pc_write) begin
            pc <= next_pc;
        end
    end

    pc_aligned_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        pc[1:0] == 2'b00
    ) else $error("steer: pc %h not word aligned", pc);

    redirect_aligned_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        redirect_valid |-> (redirect_pc[1:0] == 2'b00)
    ) else $error("steer: misaligned redirect_pc %h", redirect_pc);

endmodule

/* verilog/inst_rom.sv */
`timescale 1ns/10ps

module inst_rom (
    input  logic [fetch_pkg::xlen-1:0] pc,
    output fetch_pkg::inst_word_u     inst
);
    import fetch_pkg::*;

    logic [xlen-1:0]       mem [imem_words];
    logic [imem_idx_w-1:0] word_idx;

    initial begin
        $readmemh("program.hex", mem);
    end

    // Word index only, upper PC bits wrap
    assign word_idx = pc[imem_idx_w+1:2];

    assign inst = mem[word_idx];

endmodule

/* verilog/fetch_unit.sv */
`timescale 1ns/10ps

module fetch_unit (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      pc_write,

    input  logic                      resolve_valid,
    input  logic [fetch_pkg::xlen-1:0] resolve_pc,
    input  logic                      resolve_taken,
    input  logic [fetch_pkg::xlen-1:0] resolve_target,

    input  logic                      redirect_valid,
    input  logic [fetch_pkg::xlen-1:0] redirect_pc,

    output logic [fetch_pkg::xlen-1:0] pc,
    output fetch_pkg::inst_word_u     inst,
    output logic                      pred_taken
);
    import fetch_pkg::*;

    logic            bht_taken;
    logic            btb_hit;
    logic [xlen-1:0] btb_target;

    fetch_steer fetch_steer_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .pc_write       (pc_write),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .inst           (inst),
        .bht_taken      (bht_taken),
        .btb_hit        (btb_hit),
        .btb_target     (btb_target),
        .pc             (pc),
        .pred_taken     (pred_taken)
    );

    branch_history_table branch_history_table_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .pc             (pc),
        .resolve_valid  (resolve_valid),
        .resolve_pc     (resolve_pc),
        .resolve_taken  (resolve_taken),
        .bht_taken      (bht_taken)
    );

    branch_target_buffer branch_target_buffer_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .pc             (pc),
        .resolve_valid  (resolve_valid),
        .resolve_pc     (resolve_pc),
        .resolve_taken  (resolve_taken),
        .resolve_target (resolve_target),
        .btb_hit        (btb_hit),
        .btb_target     (btb_target)
    );

    inst_rom inst_rom_inst (
        .pc             (pc),
        .inst           (inst)
    );

endmodule

/* bench/fetch_tb.sv */
`timescale 1ns/10ps

module fetch_tb;
    import fetch_pkg::*;

    localparam int num_cycles     = 3000;
    localparam int reset_cycles   = 2;
    localparam int timeout_cycles = num_cycles + num_cycles / 3;
    // Words actually present in program.hex
    localparam int prog_words     = 32;

    logic            clk;
    logic            arst_n;
    logic            pc_write;
    logic            resolve_valid;
    logic [xlen-1:0] resolve_pc;
    logic            resolve_taken;
    logic [xlen-1:0] resolve_target;
    logic            redirect_valid;
    logic [xlen-1:0] redirect_pc;
    logic [xlen-1:0] pc;
    inst_word_u      inst;
    logic            pred_taken;

    // Reference model state
    logic [xlen-1:0]      ref_mem    [imem_words];
    logic [1:0]           ref_ctr    [bht_entries];
    logic                 ref_valid  [btb_entries];
    logic [btb_tag_w-1:0] ref_tag    [btb_entries];
    logic [xlen-1:0]      ref_target [btb_entries];
    logic [xlen-1:0]      exp_pc;

    int          cycle_count = 0;

    fetch_unit fetch_unit_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .pc_write       (pc_write),
        .resolve_valid  (resolve_valid),
        .resolve_pc     (resolve_pc),
        .resolve_taken  (resolve_taken),
        .resolve_target (resolve_target),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .pc             (pc),
        .inst           (inst),
        .pred_taken     (pred_taken)
    );

    initial begin
        $readmemh("program.hex", ref_mem);
    end

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    function automatic logic [xlen-1:0] word_addr(input int unsigned idx);
        return {idx[xlen-3:0], 2'b00};
    endfunction

    // Expected prediction for the word fetched at cur_pc
    function automatic void predict_next(
        input  logic [xlen-1:0] cur_pc,
        input  logic [xlen-1:0] word,
        output logic            taken,
        output logic [xlen-1:0] next_pc
    );
        logic [xlen-1:0]      j_imm;
        logic [bht_idx_w-1:0] bi;
        logic [btb_idx_w-1:0] ti;
        logic                 hit;

        j_imm = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
        bi    = cur_pc[bht_idx_w+1:2];
        ti    = cur_pc[btb_idx_w+1:2];
        hit   = ref_valid[ti] && (ref_tag[ti] == cur_pc[xlen-1:btb_idx_w+2]);

        if (word[6:0] == opc_jal) begin
            taken   = 1'b1;
            next_pc = cur_pc + j_imm;
        end else if ((word[6:0] == opc_branch) && hit && ref_ctr[bi][1]) begin
            taken   = 1'b1;
            next_pc = ref_target[ti];
        end else begin
            taken   = 1'b0;
            next_pc = cur_pc + 32'd4;
        end
    endfunction

    task automatic reset_model();
        exp_pc = reset_pc;
        for (int i = 0; i < bht_entries; i++) begin
            ref_ctr[i] = ctr_weak_nt;
        end
        for (int i = 0; i < btb_entries; i++) begin
            ref_valid[i] = 1'b0;
        end
    endtask

    // Apply the inputs of the current cycle as the next clock edge would
    task automatic advance_model(input logic [xlen-1:0] next_pc);
        logic [bht_idx_w-1:0] bi;
        logic [btb_idx_w-1:0] ti;

        bi = resolve_pc[bht_idx_w+1:2];
        ti = resolve_pc[btb_idx_w+1:2];
        if (resolve_valid) begin
            if (resolve_taken) begin
                if (ref_ctr[bi] != 2'b11) begin
                    ref_ctr[bi] = ref_ctr[bi] + 2'd1;
                end
                ref_valid[ti]  = 1'b1;
                ref_tag[ti]    = resolve_pc[xlen-1:btb_idx_w+2];
                ref_target[ti] = resolve_target;
            end else begin
                if (ref_ctr[bi] != 2'b00) begin
                    ref_ctr[bi] = ref_ctr[bi] - 2'd1;
                end
            end
        end
        if (redirect_valid) begin
            exp_pc = redirect_pc;
        end else if (pc_write) begin
            exp_pc = next_pc;
        end
    endtask

    task automatic fail_run(input string reason);
        $display("error at %0t ns: %s", $time, reason);
        $display("Test failed");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic check_pc(input logic [xlen-1:0] got, input logic [xlen-1:0] want);
        if (got !== want) begin
            fail_run($sformatf("pc is %h, expected %h", got, want));
        end
    endtask

    task automatic check_inst(input inst_word_u got, input inst_word_u want,
                              input logic [xlen-1:0] at_pc);
        if (got !== want) begin
            fail_run($sformatf("inst at pc %h is %h, expected %h", at_pc, got, want));
        end
    endtask

    task automatic check_pred(input logic got, input logic want, input logic [xlen-1:0] at_pc);
        if (got !== want) begin
            fail_run($sformatf("pred_taken at pc %h is %b, expected %b", at_pc, got, want));
        end
    endtask

    // Mid-cycle compare, outputs are settled by now
    always @(negedge clk) begin : compare_outputs
        logic [xlen-1:0] exp_word;
        logic            exp_pred;
        logic [xlen-1:0] exp_next;

        if (arst_n !== 1'b1) begin
            reset_model();
        end else begin
            exp_word = ref_mem[exp_pc[imem_idx_w+1:2]];
            predict_next(exp_pc, exp_word, exp_pred, exp_next);
            check_pc(pc, exp_pc);
            check_inst(inst, exp_word, exp_pc);
            check_pred(pred_taken, exp_pred, exp_pc);
            advance_model(exp_next);
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("Test failed");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic drive_random_inputs();
        int unsigned roll;

        roll = $urandom_range(99);
        pc_write <= (roll >= 15);

        roll = $urandom_range(99);
        if (roll < 30) begin
            resolve_valid <= 1'b1;
            // exp_pc already holds the PC of the coming cycle
            if ($urandom_range(1) == 0) begin
                resolve_pc <= exp_pc;
            end else begin
                resolve_pc <= word_addr($urandom_range(imem_words - 1));
            end
            resolve_taken  <= ($urandom_range(99) < 60);
            resolve_target <= word_addr($urandom_range(prog_words - 1));
        end else begin
            resolve_valid  <= 1'b0;
            resolve_taken  <= 1'b0;
        end

        roll = $urandom_range(99);
        if (roll < 3) begin
            redirect_valid <= 1'b1;
            redirect_pc    <= word_addr($urandom_range(prog_words - 1));
        end else begin
            redirect_valid <= 1'b0;
        end
    endtask

    initial begin
        void'($urandom(23324));

        arst_n         = 1'b0;
        pc_write       = 1'b0;
        resolve_valid  = 1'b0;
        resolve_pc     = '0;
        resolve_taken  = 1'b0;
        resolve_target = '0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;

        repeat (reset_cycles) @(posedge clk);
        arst_n   <= 1'b1;
        pc_write <= 1'b1;

        for (int i = 0; i < num_cycles; i++) begin
            @(posedge clk);
            drive_random_inputs();
        end

        @(posedge clk);
        resolve_valid  <= 1'b0;
        redirect_valid <= 1'b0;
        pc_write       <= 1'b1;
        repeat (2) @(posedge clk);

        $display("Test completed successfully");
        $finish;
    end

endmodule

/* filelist.f */
verilog/fetch_pkg.sv
verilog/branch_history_table.sv
verilog/branch_target_buffer.sv
verilog/fetch_steer.sv
verilog/inst_rom.sv
verilog/fetch_unit.sv
bench/fetch_tb.sv

/* program.hex */
// One 32-bit instruction word per line in hex, word 0 at address 0
// Branches, jal and plain ALU words, jal at the last word loops back to 0
00000013
00108093
00208463
002081B3
40208233
FE209CE3
00108093
00B50663
00000013
002081B3
010000EF
00000013
0020C863
00108093
40208233
00208463
00000013
FE209CE3
002081B3
00B50663
0080006F
00108093
0020C863
00000013
40208233
00208463
002081B3
00108093
FE209CE3
00000013
00B50663
F85FF06F
